/* source/soc_settings.svh */
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Data RAM size in bytes, a multiple of 4.
`define SOC_RAM_SIZE    256

// Peripheral window, end address is exclusive.
`define SOC_PERIPH_BASE 32'h8000_0000
`define SOC_PERIPH_END  32'h8000_6000

`define SOC_LEDS_ADDR   32'h8000_0000 // LED register word.

`define SOC_IRQ_LINES   32

// Read-select codes, NONE is zero so the reset selector reads as zero.
`define SOC_RDSEL_NONE  2'd0
`define SOC_RDSEL_MEM   2'd1
`define SOC_RDSEL_LEDS  2'd2

`endif

/* source/bus_pkg.sv */
package bus_pkg;

  // Target of a data-port access.
  typedef enum logic [1:0] {
    REGION_RAM     = 2'd0, // Below the RAM size.
    REGION_LEDS    = 2'd1, // LED register word.
    REGION_PERIPH  = 2'd2, // Inside the peripheral window, nothing mapped.
    REGION_INVALID = 2'd3
  } region_e;

endpackage

/* source/irq_pkg.sv */
`include "soc_settings.svh"

package irq_pkg;

  typedef logic [$clog2(`SOC_IRQ_LINES)-1:0] irq_idx_t;

  // Field view of mcause as the controller builds it.
  typedef struct packed {
    logic        irq;  // Set for interrupts.
    logic [30:0] code;
  } mcause_fields_t;

  // Raw view is what the core reads.
  typedef union packed {
    logic [31:0]    raw;
    mcause_fields_t f;
  } mcause_u;

  function automatic mcause_u mcause_irq(irq_idx_t idx);
    mcause_u m;
    m.raw    = '0;
    m.f.irq  = 1'b1;
    m.f.code = 31'(idx);
    return m;
  endfunction

endpackage

/* source/address_decoder.sv */
`timescale 1ns/1ns
`include "soc_settings.svh"

module address_decoder import bus_pkg::*; (
  input  logic [31:0] addr_i,
  input  logic        req_i,
  input  logic        we_i,
  output region_e     region_o,
  output logic        ram_req_o,
  output logic        ram_we_o,
  output logic        leds_we_o,
  output logic [1:0]  rdsel_o
);

  logic in_periph;

  assign in_periph = (addr_i >= `SOC_PERIPH_BASE) && (addr_i < `SOC_PERIPH_END);

  always_comb begin
    if (addr_i < 32'(`SOC_RAM_SIZE)) begin
      region_o = REGION_RAM;
    end else if (addr_i == `SOC_LEDS_ADDR) begin
      region_o = REGION_LEDS;
    end else if (in_periph) begin
      region_o = REGION_PERIPH;
    end else begin
      region_o = REGION_INVALID;
    end
  end

  // Only the selected target sees the request.
  assign ram_req_o = req_i && (region_o == REGION_RAM);
  assign ram_we_o  = ram_req_o && we_i;
  assign leds_we_o = req_i && we_i && (region_o == REGION_LEDS);

  always_comb begin
    rdsel_o = `SOC_RDSEL_NONE; // Writes and idle cycles.
    if (req_i && !we_i) begin
      case (region_o)
        REGION_RAM:  rdsel_o = `SOC_RDSEL_MEM;
        REGION_LEDS: rdsel_o = `SOC_RDSEL_LEDS;
        default:     rdsel_o = `SOC_RDSEL_NONE;
      endcase
    end
  end

endmodule

/* source/data_ram.sv */
`timescale 1ns/1ns
`include "soc_settings.svh"

module data_ram (
  input  logic        clk_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata_o,
  input  logic [31:0] instr_addr_i,
  output logic [31:0] instr_rdata_o
);

  localparam int WORDS = `SOC_RAM_SIZE / 4;
  localparam int AW    = $clog2(WORDS);

  logic [31:0]   mem [WORDS];
  logic [AW-1:0] data_word;
  logic [AW-1:0] instr_word;

  // Byte addresses, word index only.
  assign data_word  = addr_i[AW+1:2];
  assign instr_word = instr_addr_i[AW+1:2];

  // Data port.
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) begin
            mem[data_word][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[data_word];
      end
    end
  end

  // Fetch port, read only.
  always_ff @(posedge clk_i) begin
    instr_rdata_o <= mem[instr_word];
  end

endmodule

/* source/leds_ctrl.sv */
`timescale 1ns/1ns

module leds_ctrl (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] leds_o
);

  logic [31:0] bit_mask;

  // Byte enables widened to a bit mask.
  assign bit_mask = {{8{be_i[3]}}, {8{be_i[2]}}, {8{be_i[1]}}, {8{be_i[0]}}};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      leds_o <= '0;
    end else if (we_i) begin
      leds_o <= (leds_o & ~bit_mask) | (wdata_i & bit_mask); // Keep disabled bytes.
    end
  end

endmodule

/* source/interrupt_controller.sv */
`timescale 1ns/1ns
`include "soc_settings.svh"

module interrupt_controller import irq_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [`SOC_IRQ_LINES-1:0] int_req_i,
  input  logic [`SOC_IRQ_LINES-1:0] mie_i,
  input  logic                      int_rst_i,
  output logic                      int_o,
  output logic [`SOC_IRQ_LINES-1:0] int_fin_o,
  output mcause_u                   mcause_o
);

  localparam logic [`SOC_IRQ_LINES-1:0] LINE_ONE = {{(`SOC_IRQ_LINES-1){1'b0}}, 1'b1};

  logic [`SOC_IRQ_LINES-1:0] pending;
  logic                      any_pending;
  logic                      idle;
  irq_idx_t                  pick;
  irq_idx_t                  served_q;

  assign pending     = int_req_i & mie_i;
  assign any_pending = |pending;

  // Not serving and not in the finish cycle.
  assign idle = !int_o && !(|int_fin_o);

  // Lowest index wins.
  always_comb begin
    pick = '0;
    for (int i = `SOC_IRQ_LINES - 1; i >= 0; i--) begin
      if (pending[i]) begin
        pick = irq_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      int_o        <= 1'b0;
      int_fin_o    <= '0;
      served_q     <= '0;
      mcause_o.raw <= '0;
    end else begin
      int_fin_o <= '0; // Pulse lasts one cycle.
      if (int_o) begin
        if (int_rst_i) begin
          int_o     <= 1'b0;
          int_fin_o <= LINE_ONE << served_q; // Acknowledge the served line.
        end
      end else if (idle && any_pending) begin
        int_o    <= 1'b1;
        served_q <= pick;
        mcause_o <= mcause_irq(pick);
      end
    end
  end

endmodule

/* source/periph_top.sv */
`timescale 1ns/1ns
`include "soc_settings.svh"

module periph_top import bus_pkg::*, irq_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_i,

  // Data port.
  input  logic                      data_req_i,
  input  logic                      data_we_i,
  input  logic [3:0]                data_be_i,
  input  logic [31:0]               data_addr_i,
  input  logic [31:0]               data_wdata_i,
  output logic [31:0]               data_rdata_o,

  // Fetch port.
  input  logic [31:0]               instr_addr_i,
  output logic [31:0]               instr_rdata_o,

  // Interrupts.
  input  logic [`SOC_IRQ_LINES-1:0] int_req_i,
  input  logic [`SOC_IRQ_LINES-1:0] mie_i,
  input  logic                      int_rst_i,
  output logic                      int_o,
  output logic [`SOC_IRQ_LINES-1:0] int_fin_o,
  output mcause_u                   mcause_o,

  output logic [15:0]               leds_o
);

  region_e     region;
  logic        ram_req;
  logic        ram_we;
  logic        leds_we;
  logic [1:0]  rdsel;
  logic [1:0]  rdsel_q;
  logic [3:0]  ram_be;
  logic [3:0]  leds_be;
  logic [31:0] ram_rdata;
  logic [31:0] leds_word;

  // Byte enables reach a target only inside its own region.
  assign ram_be  = (region == REGION_RAM) ? data_be_i : 4'b0000;
  assign leds_be = (region == REGION_LEDS) ? data_be_i : 4'b0000;

  assign leds_o = leds_word[15:0];

  address_decoder u_decoder (
    .addr_i    (data_addr_i),
    .req_i     (data_req_i),
    .we_i      (data_we_i),
    .region_o  (region),
    .ram_req_o (ram_req),
    .ram_we_o  (ram_we),
    .leds_we_o (leds_we),
    .rdsel_o   (rdsel)
  );

  data_ram u_ram (
    .clk_i         (clk_i),
    .req_i         (ram_req),
    .we_i          (ram_we),
    .be_i          (ram_be),
    .addr_i        (data_addr_i),
    .wdata_i       (data_wdata_i),
    .rdata_o       (ram_rdata),
    .instr_addr_i  (instr_addr_i),
    .instr_rdata_o (instr_rdata_o)
  );

  leds_ctrl u_leds (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .we_i    (leds_we),
    .be_i    (leds_be),
    .wdata_i (data_wdata_i),
    .leds_o  (leds_word)
  );

  interrupt_controller u_irq (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .int_req_i (int_req_i),
    .mie_i     (mie_i),
    .int_rst_i (int_rst_i),
    .int_o     (int_o),
    .int_fin_o (int_fin_o),
    .mcause_o  (mcause_o)
  );

  // Selector follows the read by one cycle, like the RAM data.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdsel_q <= `SOC_RDSEL_NONE;
    end else begin
      rdsel_q <= rdsel;
    end
  end

  always_comb begin
    case (rdsel_q)
      `SOC_RDSEL_MEM:  data_rdata_o = ram_rdata;
      `SOC_RDSEL_LEDS: data_rdata_o = leds_word; // Full register word.
      default:         data_rdata_o = '0;        // Unmapped and invalid.
    endcase
  end

endmodule

/* bench/periph_assertions.sv */
`timescale 1ns/1ns
`include "soc_settings.svh"

module periph_assertions (
  input logic                      clk_i,
  input logic                      rst_i,
  input logic                      int_i,
  input logic [`SOC_IRQ_LINES-1:0] int_fin_i,
  input logic                      ram_we_i,
  input logic                      leds_we_i
);

  int fail_count = 0; // Failed assertions so far.

  fin_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(int_fin_i))
    else begin
      $error("int_fin_o has more than one line set");
      fail_count++;
    end

  // Finish pulse comes only after int_o has dropped.
  fin_not_during_int: assert property (@(posedge clk_i) disable iff (rst_i)
    !(int_i && (|int_fin_i)))
    else begin
      $error("int_fin_o pulsed while int_o was high");
      fail_count++;
    end

  single_writer: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({ram_we_i, leds_we_i}))
    else begin
      $error("more than one target saw a write");
      fail_count++;
    end

endmodule

bind periph_top periph_assertions u_assert (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .int_i     (int_o),
  .int_fin_i (int_fin_o),
  .ram_we_i  (ram_we),
  .leds_we_i (leds_we)
);

/* bench/periph_tb.sv */
`timescale 1ns/1ns
`include "soc_settings.svh"

module periph_tb;

  localparam int RAM_WORDS    = `SOC_RAM_SIZE / 4;
  localparam int PERIPH_WORDS = int'((`SOC_PERIPH_END - `SOC_PERIPH_BASE) / 4);
  localparam int N_PARTIAL    = 64;
  localparam int N_LEDS       = 16;
  localparam int N_UNMAPPED   = 32;
  localparam int N_FETCH      = 32;
  localparam int N_IRQ        = 40;
  localparam int TOTAL_CYCLES = 3 * RAM_WORDS + 2 * N_PARTIAL + 2 * N_LEDS
                              + 2 * N_UNMAPPED + 1 + N_FETCH + 6 * N_IRQ;
  localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 2 + 200) * 100; // Reset and margin added.

  logic                      clk;
  logic                      rst;
  logic                      data_req;
  logic                      data_we;
  logic [3:0]                data_be;
  logic [31:0]               data_addr;
  logic [31:0]               data_wdata;
  logic [31:0]               data_rdata;
  logic [31:0]               instr_addr;
  logic [31:0]               instr_rdata;
  logic [`SOC_IRQ_LINES-1:0] int_req;
  logic [`SOC_IRQ_LINES-1:0] mie;
  logic                      int_rst;
  logic                      int_out;
  logic [`SOC_IRQ_LINES-1:0] int_fin;
  logic [31:0]               mcause;
  logic [15:0]               leds;

  // Reference model.
  logic [31:0] ram_model [RAM_WORDS];
  logic [31:0] leds_model;

  string test_name = "reset";
  int    error_count = 0;

  periph_top dut (
    .clk_i         (clk),
    .rst_i         (rst),
    .data_req_i    (data_req),
    .data_we_i     (data_we),
    .data_be_i     (data_be),
    .data_addr_i   (data_addr),
    .data_wdata_i  (data_wdata),
    .data_rdata_o  (data_rdata),
    .instr_addr_i  (instr_addr),
    .instr_rdata_o (instr_rdata),
    .int_req_i     (int_req),
    .mie_i         (mie),
    .int_rst_i     (int_rst),
    .int_o         (int_out),
    .int_fin_o     (int_fin),
    .mcause_o      (mcause),
    .leds_o        (leds)
  );

  always #50 clk = ~clk;

  task automatic stop_with_failure(input string reason);
    $display("Finished with errors");
    $fatal(1, "%s", reason);
  endtask

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
      stop_with_failure("a checked value did not match");
    end
  endtask

  // Called at a falling edge and returns at the next one.
  task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata);
    data_req   = 1'b1;
    data_we    = 1'b1;
    data_be    = be;
    data_addr  = addr;
    data_wdata = wdata;
    @(negedge clk);
    data_req = 1'b0;
    data_we  = 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    data_req  = 1'b1;
    data_we   = 1'b0;
    data_be   = 4'b1111;
    data_addr = addr;
    @(negedge clk);
    rdata    = data_rdata; // Valid in the cycle after the request.
    data_req = 1'b0;
  endtask

  function automatic logic [31:0] merge_bytes(logic [31:0] old_word, logic [31:0] new_word,
                                              logic [3:0] be);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  function automatic int lowest_pending(logic [`SOC_IRQ_LINES-1:0] req,
                                        logic [`SOC_IRQ_LINES-1:0] en);
    for (int i = 0; i < `SOC_IRQ_LINES; i++) begin
      if (req[i] && en[i]) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic fill_ram();
    logic [31:0] rdata;
    test_name = "ram_fill";
    for (int w = 0; w < RAM_WORDS; w++) begin
      ram_model[w] = $urandom;
      bus_write(32'(w) * 4, 4'b1111, ram_model[w]);
    end
    for (int w = 0; w < RAM_WORDS; w++) begin
      bus_read(32'(w) * 4, rdata);
      check("read word", ram_model[w], rdata);
    end
  endtask

  task automatic partial_writes();
    logic [31:0] rdata;
    logic [31:0] wdata;
    logic [3:0]  be;
    int          w;
    test_name = "ram_partial";
    for (int n = 0; n < N_PARTIAL; n++) begin
      w     = int'($urandom_range(RAM_WORDS - 1, 0));
      be    = 4'($urandom_range(15, 1));
      wdata = $urandom;
      ram_model[w] = merge_bytes(ram_model[w], wdata, be);
      bus_write(32'(w) * 4, be, wdata);
      bus_read(32'(w) * 4, rdata);
      check("merged word", ram_model[w], rdata);
    end
  endtask

  task automatic led_register();
    logic [31:0] rdata;
    logic [31:0] wdata;
    logic [3:0]  be;
    test_name = "leds";
    for (int n = 0; n < N_LEDS; n++) begin
      be    = 4'($urandom_range(15, 0));
      wdata = $urandom;
      leds_model = merge_bytes(leds_model, wdata, be);
      bus_write(`SOC_LEDS_ADDR, be, wdata);
      check("leds_o", {16'h0000, leds_model[15:0]}, {16'h0000, leds});
      bus_read(`SOC_LEDS_ADDR, rdata);
      check("read word", leds_model, rdata);
    end
  endtask

  task automatic unmapped_access();
    logic [31:0] rdata;
    logic [31:0] addr;
    int          kind;
    test_name = "unmapped";
    for (int n = 0; n < N_UNMAPPED; n++) begin
      kind = int'($urandom_range(2, 0));
      if (kind == 0) begin
        addr = `SOC_PERIPH_BASE + 32'($urandom_range(PERIPH_WORDS - 1, 1)) * 4;
      end else if (kind == 1) begin
        addr = 32'(`SOC_RAM_SIZE) + 32'($urandom_range(32'h0FFF_FFFF, 0)) * 4;
      end else begin
        addr = 32'h9000_0000 + 32'($urandom_range(32'h0FFF_FFFF, 0)) * 4;
      end
      bus_write(addr, 4'($urandom_range(15, 0)), $urandom);
      bus_read(addr, rdata);
      check("read zero", 32'h0000_0000, rdata);
    end
    // Nothing else may have changed.
    for (int w = 0; w < RAM_WORDS; w++) begin
      bus_read(32'(w) * 4, rdata);
      check("ram kept", ram_model[w], rdata);
    end
    bus_read(`SOC_LEDS_ADDR, rdata);
    check("leds kept", leds_model, rdata);
  endtask

  task automatic fetch_reads();
    int w;
    test_name = "fetch";
    for (int n = 0; n < N_FETCH; n++) begin
      w = int'($urandom_range(RAM_WORDS - 1, 0));
      instr_addr = 32'(w) * 4;
      @(negedge clk);
      check("instr word", ram_model[w], instr_rdata);
    end
  endtask

  task automatic interrupt_sequences();
    int idx;
    int hold;
    test_name = "interrupts";
    for (int n = 0; n < N_IRQ; n++) begin
      int_req = $urandom & $urandom;
      mie     = ($urandom_range(7, 0) == 0) ? '0 : $urandom;
      idx     = lowest_pending(int_req, mie);
      @(negedge clk);
      if (idx < 0) begin
        check("int_o idle", 32'd0, 32'(int_out));
        check("int_fin idle", 32'd0, int_fin);
      end else begin
        check("int_o raised", 32'd1, 32'(int_out));
        check("mcause", {1'b1, 31'(idx)}, mcause);
        hold = int'($urandom_range(2, 0));
        for (int h = 0; h < hold; h++) begin
          int_req = $urandom; // Ignored while serving.
          @(negedge clk);
          check("int_o held", 32'd1, 32'(int_out));
          check("mcause held", {1'b1, 31'(idx)}, mcause);
        end
        int_rst = 1'b1;
        int_req = mie; // Still pending, so no new request before the finish cycle ends.
        @(negedge clk);
        int_rst = 1'b0;
        check("int_o dropped", 32'd0, 32'(int_out));
        check("int_fin pulse", 32'(1) << idx, int_fin);
        @(negedge clk);
        check("int_fin cleared", 32'd0, int_fin);
        check("int_o stays low", 32'd0, 32'(int_out));
      end
    end
    int_req = '0;
    mie     = '0;
  endtask

  always @(negedge clk) begin
    if (dut.u_assert.fail_count != 0) begin
      stop_with_failure("a bound assertion fired");
    end
  end

  initial begin
    #(TIMEOUT_NS);
    stop_with_failure("watchdog expired before the tests completed");
  end

  initial begin
    void'($urandom(32'h4839_015d));
    clk        = 1'b0;
    rst        = 1'b1;
    data_req   = 1'b0;
    data_we    = 1'b0;
    data_be    = 4'b0000;
    data_addr  = 32'h0000_0000;
    data_wdata = 32'h0000_0000;
    instr_addr = 32'h0000_0000;
    int_req    = '0;
    mie        = '0;
    int_rst    = 1'b0;
    leds_model = 32'h0000_0000;
    repeat (2) @(negedge clk);
    rst = 1'b0;

    check("leds_o", 32'd0, {16'h0000, leds});
    check("int_o", 32'd0, 32'(int_out));
    check("int_fin", 32'd0, int_fin);
    check("mcause", 32'd0, mcause);
    check("rdata", 32'd0, data_rdata);

    fill_ram();
    partial_writes();
    led_register();
    unmapped_access();
    fetch_reads();
    interrupt_sequences();

    if (error_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      stop_with_failure("checks failed during the run");
    end
  end

endmodule

/* list.f */
+incdir+source
source/bus_pkg.sv
source/irq_pkg.sv
source/address_decoder.sv
source/data_ram.sv
source/leds_ctrl.sv
source/interrupt_controller.sv
source/periph_top.sv
bench/periph_assertions.sv
bench/periph_tb.sv

/* Makefile */
# Verilator build and run for the peripheral block.

VERILATOR ?= verilator
TOP       ?= periph_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_FLAGS ?= +verilator+error+limit+100
PASS_TEXT ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR VFLAGS SIM_FLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) \
	  --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
